//--- source/ncq_req_pkg.sv
// Request word definitions for the exclusive-access queue path
// Field widths, field struct and the two-view request union
package ncq_req_pkg;

  // Field widths
  localparam int ADDRW = 40;
  localparam int IDW   = 8;
  localparam int SIZEW = 3;

  // Whole request word of addr, id, size and lock
  localparam int REQW  = ADDRW + IDW + SIZEW + 1;

  // Field layout from the MSB down
  typedef struct packed {
    logic [ADDRW-1:0] addr;
    logic [IDW-1:0]   id;
    logic [SIZEW-1:0] size;
    logic             lock;
  } ncq_req_fields_t;

  // Same word seen as fields or as one raw vector
  // Fields for address compare and lock test
  // Raw for whole-word reservation match
  typedef union packed {
    ncq_req_fields_t   fields;
    logic [REQW-1:0]   raw;
  } ncq_req_u;

endpackage

//--- source/ncq_resp_pkg.sv
// Response definitions for the read and write response channels
// Response code enum and response struct
package ncq_resp_pkg;

  // Two-bit response code
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01
  } ncq_resp_e;

  // Returned id and code
  typedef struct packed {
    logic [ncq_req_pkg::IDW-1:0] id;
    ncq_resp_e                   code;
  } ncq_resp_t;

endpackage

//--- source/ncq_addr_queue.sv
// Address request FIFO as a circular buffer with occupancy count
// Valid/ready push side and a visible head popped by the response stage
module ncq_addr_queue #(
  parameter int DEPTH = 4
) (
  input  logic                  gm_clk,
  input  logic                  cpurst_b,
  input  logic                  in_valid,
  input  ncq_req_pkg::ncq_req_u in_req,
  input  logic                  pop,
  output logic                  in_ready,
  output logic                  head_valid,
  output ncq_req_pkg::ncq_req_u head_req
);

  localparam int PTRW = $clog2(DEPTH);

  // Storage and pointers
  ncq_req_pkg::ncq_req_u mem [DEPTH];
  logic [PTRW-1:0]       wr_ptr;
  logic [PTRW-1:0]       rd_ptr;
  logic [PTRW:0]         count;

  logic                  full;
  logic                  push;
  logic                  pop_en;

  assign full       = (count == (PTRW+1)'(DEPTH));
  assign head_valid = (count != '0);

  // Full queue still takes a push when the head leaves this cycle
  assign in_ready   = !full || pop_en;
  assign push       = in_valid && in_ready;

  // Pop only ever removes a real entry
  assign pop_en     = pop && head_valid;

  // Head is always on view for the monitor
  assign head_req   = mem[rd_ptr];

  // Pointer and occupancy update
  always_ff @(posedge gm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_en)
        rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous push and pop leaves count unchanged
      if (push && !pop_en)
        count <= count + 1'b1;
      else if (pop_en && !push)
        count <= count - 1'b1;
    end
  end

  // Entry write with pointers wrapping at the power-of-two depth
  always_ff @(posedge gm_clk)
  begin
    if (push)
      mem[wr_ptr] <= in_req;
  end

endmodule

//--- source/ncq_global_monitor.sv
// Global exclusive monitor with one reservation
// Reservation flag and stored word, match logic and response codes
module ncq_global_monitor (
  input  logic                   gm_clk,
  input  logic                   cpurst_b,
  input  logic                   raq_pop,
  input  ncq_req_pkg::ncq_req_u  raq_head,
  input  logic                   waq_pop,
  input  ncq_req_pkg::ncq_req_u  waq_head,
  output ncq_resp_pkg::ncq_resp_e rd_code,
  output ncq_resp_pkg::ncq_resp_e wr_code,
  output logic                   gm_vld
);

  // Reservation state
  logic                  gm_exclusive;
  ncq_req_pkg::ncq_req_u gm_cont;

  logic                  gm_set;
  logic                  gm_clr;
  logic                  gm_success;

  // Locked read pop takes the reservation
  assign gm_set = raq_pop && raq_head.fields.lock;

  // Any write pop to the stored address drops it
  assign gm_clr = waq_pop && (waq_head.fields.addr == gm_cont.fields.addr);

  // Exclusive write needs lock, a live reservation and the identical word
  // Judged on pre-edge state only
  assign gm_success = waq_pop && waq_head.fields.lock && gm_exclusive &&
                      (waq_head.raw == gm_cont.raw);

  assign rd_code = gm_set     ? ncq_resp_pkg::EXOKAY : ncq_resp_pkg::OKAY;
  assign wr_code = gm_success ? ncq_resp_pkg::EXOKAY : ncq_resp_pkg::OKAY;

  // Flag update where clear beats set
  always_ff @(posedge gm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      gm_exclusive <= 1'b0;
    else if (gm_clr)
      gm_exclusive <= 1'b0;
    else if (gm_set)
      gm_exclusive <= 1'b1;
  end

  // Stored word follows every locked read even when a clear wins
  always_ff @(posedge gm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      gm_cont <= '0;
    else if (gm_set)
      gm_cont <= raq_head;
  end

  // Reservation state out to the checker
  assign gm_vld = gm_exclusive;

endmodule

//--- source/ncq_resp_gen.sv
// Response stage for the read and write channels
// One holding register per channel, pop control and response assembly
module ncq_resp_gen (
  input  logic                          gm_clk,
  input  logic                          cpurst_b,
  input  logic                          raq_valid,
  input  logic [ncq_req_pkg::IDW-1:0]   raq_id,
  input  logic                          waq_valid,
  input  logic [ncq_req_pkg::IDW-1:0]   waq_id,
  input  ncq_resp_pkg::ncq_resp_e       rd_code,
  input  ncq_resp_pkg::ncq_resp_e       wr_code,
  input  logic                          r_ready,
  input  logic                          b_ready,
  output logic                          raq_pop,
  output logic                          waq_pop,
  output logic                          r_valid,
  output ncq_resp_pkg::ncq_resp_t       r_resp,
  output logic                          b_valid,
  output ncq_resp_pkg::ncq_resp_t       b_resp
);

  // Channel index 0 is read, 1 is write
  logic [1:0]              q_valid;
  logic [1:0]              rsp_ready;
  logic [1:0]              pop;
  logic [1:0]              rsp_valid;
  ncq_resp_pkg::ncq_resp_t new_resp [2];
  ncq_resp_pkg::ncq_resp_t rsp_q    [2];

  assign q_valid   = {waq_valid, raq_valid};
  assign rsp_ready = {b_ready, r_ready};

  // Popped id paired with the monitor's code
  assign new_resp[0] = '{id: raq_id, code: rd_code};
  assign new_resp[1] = '{id: waq_id, code: wr_code};

  // Pop when the head is valid and the register is empty or draining
  always_comb
  begin
    for (int i = 0; i < 2; i++)
      pop[i] = q_valid[i] && (!rsp_valid[i] || rsp_ready[i]);
  end

  // Valid flags
  always_ff @(posedge gm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rsp_valid <= '0;
    else
    begin
      for (int i = 0; i < 2; i++)
      begin
        if (pop[i])
          rsp_valid[i] <= 1'b1;
        else if (rsp_ready[i])
          rsp_valid[i] <= 1'b0;
      end
    end
  end

  // Payload loads only on pop and holds under back-pressure
  always_ff @(posedge gm_clk)
  begin
    for (int i = 0; i < 2; i++)
    begin
      if (pop[i])
        rsp_q[i] <= new_resp[i];
    end
  end

  // Channel outputs
  assign raq_pop = pop[0];
  assign waq_pop = pop[1];
  assign r_valid = rsp_valid[0];
  assign r_resp  = rsp_q[0];
  assign b_valid = rsp_valid[1];
  assign b_resp  = rsp_q[1];

endmodule

//--- source/ncq_excl_top.sv
// Exclusive-access path top level
// Read and write address queues, global monitor and response stage
module ncq_excl_top #(
  parameter int DEPTH = 4
) (
  input  logic                    gm_clk,
  input  logic                    cpurst_b,
  // Read address channel
  input  logic                    ar_valid,
  output logic                    ar_ready,
  input  ncq_req_pkg::ncq_req_u   ar_req,
  // Write address channel
  input  logic                    aw_valid,
  output logic                    aw_ready,
  input  ncq_req_pkg::ncq_req_u   aw_req,
  // Read response channel
  output logic                    r_valid,
  input  logic                    r_ready,
  output ncq_resp_pkg::ncq_resp_t r_resp,
  // Write response channel
  output logic                    b_valid,
  input  logic                    b_ready,
  output ncq_resp_pkg::ncq_resp_t b_resp
);

  // Queue heads and pop strobes
  logic                    raq_valid;
  ncq_req_pkg::ncq_req_u   raq_head;
  logic                    raq_pop;
  logic                    waq_valid;
  ncq_req_pkg::ncq_req_u   waq_head;
  logic                    waq_pop;

  // Monitor decisions for the popped heads
  ncq_resp_pkg::ncq_resp_e rd_code;
  ncq_resp_pkg::ncq_resp_e wr_code;
  logic                    gm_vld;

  // Read address queue
  ncq_addr_queue #(.DEPTH(DEPTH)) raq_i (
    .gm_clk     (gm_clk),
    .cpurst_b   (cpurst_b),
    .in_valid   (ar_valid),
    .in_req     (ar_req),
    .pop        (raq_pop),
    .in_ready   (ar_ready),
    .head_valid (raq_valid),
    .head_req   (raq_head)
  );

  // Write address queue
  ncq_addr_queue #(.DEPTH(DEPTH)) waq_i (
    .gm_clk     (gm_clk),
    .cpurst_b   (cpurst_b),
    .in_valid   (aw_valid),
    .in_req     (aw_req),
    .pop        (waq_pop),
    .in_ready   (aw_ready),
    .head_valid (waq_valid),
    .head_req   (waq_head)
  );

  // Exclusive monitor
  ncq_global_monitor gm_i (
    .gm_clk   (gm_clk),
    .cpurst_b (cpurst_b),
    .raq_pop  (raq_pop),
    .raq_head (raq_head),
    .waq_pop  (waq_pop),
    .waq_head (waq_head),
    .rd_code  (rd_code),
    .wr_code  (wr_code),
    .gm_vld   (gm_vld)
  );

  // Response stage
  ncq_resp_gen resp_i (
    .gm_clk    (gm_clk),
    .cpurst_b  (cpurst_b),
    .raq_valid (raq_valid),
    .raq_id    (raq_head.fields.id),
    .waq_valid (waq_valid),
    .waq_id    (waq_head.fields.id),
    .rd_code   (rd_code),
    .wr_code   (wr_code),
    .r_ready   (r_ready),
    .b_ready   (b_ready),
    .raq_pop   (raq_pop),
    .waq_pop   (waq_pop),
    .r_valid   (r_valid),
    .r_resp    (r_resp),
    .b_valid   (b_valid),
    .b_resp    (b_resp)
  );

endmodule

//--- tb/ncq_excl_checker.sv
// Bound assertions on the exclusive-access top level
// Reset values, response stability under back-pressure, no pop from an empty queue
module ncq_excl_checker (
  input logic                    gm_clk,
  input logic                    cpurst_b,
  input logic                    ar_valid,
  input logic                    ar_ready,
  input logic                    aw_valid,
  input logic                    aw_ready,
  input logic                    r_valid,
  input logic                    r_ready,
  input ncq_resp_pkg::ncq_resp_t r_resp,
  input logic                    b_valid,
  input logic                    b_ready,
  input ncq_resp_pkg::ncq_resp_t b_resp,
  input logic                    raq_pop,
  input logic                    waq_pop,
  input logic                    gm_vld
);

  // Failure count read back by the testbench
  int assert_errs = 0;

  // Requests accepted on each channel and not yet popped
  logic [7:0] rd_pend;
  logic [7:0] wr_pend;

  always_ff @(posedge gm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      rd_pend <= '0;
      wr_pend <= '0;
    end
    else
    begin
      rd_pend <= rd_pend + 8'(ar_valid && ar_ready) - 8'(raq_pop);
      wr_pend <= wr_pend + 8'(aw_valid && aw_ready) - 8'(waq_pop);
    end
  end

  // Responses and reservation low in reset
  rst_low_a : assert property (@(posedge gm_clk)
    !cpurst_b |-> !r_valid && !b_valid && !gm_vld)
    else
    begin
      assert_errs++;
      $error("Response valid or reservation high during reset");
    end

  // Held read response under back-pressure
  r_hold_a : assert property (@(posedge gm_clk) disable iff (!cpurst_b)
    r_valid && !r_ready |=> r_valid && $stable(r_resp))
    else
    begin
      assert_errs++;
      $error("Read response changed or dropped while stalled");
    end

  // Held write response under back-pressure
  b_hold_a : assert property (@(posedge gm_clk) disable iff (!cpurst_b)
    b_valid && !b_ready |=> b_valid && $stable(b_resp))
    else
    begin
      assert_errs++;
      $error("Write response changed or dropped while stalled");
    end

  // Pops only while an accepted request is still waiting
  pop_pending_a : assert property (@(posedge gm_clk) disable iff (!cpurst_b)
    (!raq_pop || rd_pend != '0) && (!waq_pop || wr_pend != '0))
    else
    begin
      assert_errs++;
      $error("Pop issued on an empty address queue");
    end

endmodule

bind ncq_excl_top ncq_excl_checker chk_i (
  .gm_clk    (gm_clk),
  .cpurst_b  (cpurst_b),
  .ar_valid  (ar_valid),
  .ar_ready  (ar_ready),
  .aw_valid  (aw_valid),
  .aw_ready  (aw_ready),
  .r_valid   (r_valid),
  .r_ready   (r_ready),
  .r_resp    (r_resp),
  .b_valid   (b_valid),
  .b_ready   (b_ready),
  .b_resp    (b_resp),
  .raq_pop   (raq_pop),
  .waq_pop   (waq_pop),
  .gm_vld    (gm_vld)
);

//--- tb/ncq_excl_tb.sv
// Testbench for the exclusive-access path
// Clock, reset, directed and random stimulus, reference model and checks
module ncq_excl_tb;

  localparam int DEPTH   = 4;
  localparam int TIMEOUT = 200;

  logic                    gm_clk;
  logic                    cpurst_b;
  logic                    ar_valid;
  logic                    ar_ready;
  ncq_req_pkg::ncq_req_u   ar_req;
  logic                    aw_valid;
  logic                    aw_ready;
  ncq_req_pkg::ncq_req_u   aw_req;
  logic                    r_valid;
  logic                    r_ready;
  ncq_resp_pkg::ncq_resp_t r_resp;
  logic                    b_valid;
  logic                    b_ready;
  ncq_resp_pkg::ncq_resp_t b_resp;
  integer                  seed;

  // Model queues and reservation
  ncq_req_pkg::ncq_req_u   rd_q [$];
  ncq_req_pkg::ncq_req_u   wr_q [$];
  logic                    m_excl;
  ncq_req_pkg::ncq_req_u   m_word;
  logic                    r_vld_d;
  logic                    r_xfer_d;
  logic                    b_vld_d;
  logic                    b_xfer_d;
  logic                    ar_acc;
  logic                    aw_acc;
  int                      wr_exok_cnt;

  ncq_excl_top #(.DEPTH(DEPTH)) dut_i (
    .gm_clk   (gm_clk),
    .cpurst_b (cpurst_b),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar_req   (ar_req),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw_req   (aw_req),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r_resp   (r_resp),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b_resp   (b_resp)
  );

  always #2 gm_clk = ~gm_clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      fail_run($sformatf("ERR t=%0t %s got 0x%0h exp 0x%0h", $time, name, got, exp));
  endtask

  // Small address pool so reservations get hit
  function automatic ncq_req_pkg::ncq_req_u make_req(input logic [1:0] a_idx,
      input logic [7:0] id, input logic [2:0] size, input logic lock);
    ncq_req_pkg::ncq_req_u req;
    req.fields.addr = 40'h00_8000_0000 + {a_idx, 6'h00};
    req.fields.id   = id;
    req.fields.size = size;
    req.fields.lock = lock;
    return req;
  endfunction

  function automatic ncq_req_pkg::ncq_req_u rand_req();
    logic [31:0] r;
    r = $random(seed);
    return make_req(r[1:0], 8'h20 + r[3:2], r[4] ? 3'd2 : 3'd3, r[5]);
  endfunction

  // Reference model sampled mid-cycle on settled signals
  always @(negedge gm_clk)
  begin : model_step
    ncq_req_pkg::ncq_req_u   rq;
    ncq_req_pkg::ncq_req_u   wq;
    ncq_resp_pkg::ncq_resp_e exp_code;
    logic                    do_clr;
    logic                    do_set;
    if (dut_i.chk_i.assert_errs != 0)
      fail_run("A bound assertion on the DUT failed");
    if (!cpurst_b)
    begin
      {ar_acc, aw_acc, r_vld_d, r_xfer_d, b_vld_d, b_xfer_d, m_excl} = '0;
      m_word = '0;
    end
    else
    begin
      ar_acc = ar_valid && ar_ready;
      aw_acc = aw_valid && aw_ready;
      if (ar_acc)
        rd_q.push_back(ar_req);
      if (aw_acc)
        wr_q.push_back(aw_req);
      do_clr = 1'b0;
      do_set = 1'b0;
      // New write response judged on the state before its pop
      if (b_valid && (!b_vld_d || b_xfer_d))
      begin
        if (wr_q.size() == 0)
          fail_run("Write response arrived with no outstanding write request");
        wq = wr_q.pop_front();
        exp_code = (wq.fields.lock && m_excl && (wq.raw == m_word.raw)) ?
                   ncq_resp_pkg::EXOKAY : ncq_resp_pkg::OKAY;
        check_val("b_resp.id", b_resp.id, wq.fields.id);
        check_val("b_resp.code", b_resp.code, exp_code);
        if (b_resp.code == ncq_resp_pkg::EXOKAY)
          wr_exok_cnt++;
        do_clr = (wq.fields.addr == m_word.fields.addr);
      end
      // New read response
      if (r_valid && (!r_vld_d || r_xfer_d))
      begin
        if (rd_q.size() == 0)
          fail_run("Read response arrived with no outstanding read request");
        rq = rd_q.pop_front();
        exp_code = rq.fields.lock ? ncq_resp_pkg::EXOKAY : ncq_resp_pkg::OKAY;
        check_val("r_resp.id", r_resp.id, rq.fields.id);
        check_val("r_resp.code", r_resp.code, exp_code);
        do_set = rq.fields.lock;
      end
      // Clear beats set and the word still loads
      if (do_clr)
        m_excl = 1'b0;
      else if (do_set)
        m_excl = 1'b1;
      if (do_set)
        m_word = rq;
      r_vld_d  = r_valid;
      r_xfer_d = r_valid && r_ready;
      b_vld_d  = b_valid;
      b_xfer_d = b_valid && b_ready;
    end
  end

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (rd_q.size() != 0 || wr_q.size() != 0 || r_valid || b_valid)
    begin
      @(negedge gm_clk);
      #1;
      waited++;
      if (waited > TIMEOUT)
        fail_run("Timeout waiting for outstanding responses to drain");
    end
  endtask

  // One request held until accepted and then drained
  task automatic send_req(input logic is_wr, input ncq_req_pkg::ncq_req_u req);
    int waited;
    waited = 0;
    @(posedge gm_clk);
    #1;
    if (is_wr)
    begin
      aw_valid = 1'b1;
      aw_req   = req;
    end
    else
    begin
      ar_valid = 1'b1;
      ar_req   = req;
    end
    do
    begin
      @(negedge gm_clk);
      #1;
      waited++;
      if (waited > TIMEOUT)
        fail_run("Timeout waiting for a request to be accepted");
    end
    while (!(is_wr ? aw_acc : ar_acc));
    @(posedge gm_clk);
    #1;
    ar_valid = 1'b0;
    aw_valid = 1'b0;
    wait_idle();
  endtask

  initial
  begin
    int waited;
    seed = 32'h165b_f143;
    {gm_clk, cpurst_b, ar_valid, aw_valid} = '0;
    ar_req = '0;
    aw_req = '0;
    r_ready = 1'b1;
    b_ready = 1'b1;
    wr_exok_cnt = 0;
    repeat (10) @(posedge gm_clk);
    #1;
    cpurst_b = 1'b1;
    @(negedge gm_clk);
    check_val("ar_ready", ar_ready, 1);
    check_val("aw_ready", aw_ready, 1);
    check_val("r_valid", r_valid, 0);
    check_val("b_valid", b_valid, 0);
    // Locked write with no reservation yet
    send_req(1'b1, make_req(2'd0, 8'h01, 3'd2, 1'b1));
    // Plain traffic
    send_req(1'b0, make_req(2'd1, 8'h02, 3'd2, 1'b0));
    send_req(1'b1, make_req(2'd2, 8'h03, 3'd2, 1'b0));
    // Reservation then identical locked write
    send_req(1'b0, make_req(2'd0, 8'h04, 3'd2, 1'b1));
    send_req(1'b1, make_req(2'd0, 8'h04, 3'd2, 1'b1));
    // Id mismatch fails but clears, so the identical one fails too
    send_req(1'b0, make_req(2'd1, 8'h05, 3'd2, 1'b1));
    send_req(1'b1, make_req(2'd1, 8'h06, 3'd2, 1'b1));
    send_req(1'b1, make_req(2'd1, 8'h05, 3'd2, 1'b1));
    // Other address keeps the reservation
    send_req(1'b0, make_req(2'd2, 8'h07, 3'd1, 1'b1));
    send_req(1'b1, make_req(2'd3, 8'h07, 3'd1, 1'b1));
    send_req(1'b1, make_req(2'd2, 8'h07, 3'd1, 1'b1));
    check_val("directed EXOKAY write count", wr_exok_cnt, 2);
    // Random traffic with back-pressure
    repeat (2000)
    begin
      @(posedge gm_clk);
      #1;
      if (!ar_valid || ar_acc)
      begin
        ar_valid = ($random(seed) & 1) != 0;
        ar_req   = rand_req();
      end
      if (!aw_valid || aw_acc)
      begin
        aw_valid = ($random(seed) & 1) != 0;
        aw_req   = rand_req();
      end
      r_ready = (($random(seed) & 32'h7fff_ffff) % 10) >= 3;
      b_ready = (($random(seed) & 32'h7fff_ffff) % 10) >= 3;
    end
    r_ready = 1'b1;
    b_ready = 1'b1;
    waited = 0;
    while (ar_valid || aw_valid)
    begin
      @(posedge gm_clk);
      #1;
      if (ar_acc)
        ar_valid = 1'b0;
      if (aw_acc)
        aw_valid = 1'b0;
      waited++;
      if (waited > TIMEOUT)
        fail_run("Timeout waiting for the last random requests to be accepted");
    end
    wait_idle();
    if (wr_exok_cnt <= 2)
      fail_run("Random traffic produced no successful exclusive write");
    else
    begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

//--- files.f
source/ncq_req_pkg.sv
source/ncq_resp_pkg.sv
source/ncq_addr_queue.sv
source/ncq_global_monitor.sv
source/ncq_resp_gen.sv
source/ncq_excl_top.sv
tb/ncq_excl_checker.sv
tb/ncq_excl_tb.sv

//--- Bender.yml
package:
  name: ncq_excl

sources:
  - files:
      - source/ncq_req_pkg.sv
      - source/ncq_resp_pkg.sv
      - source/ncq_addr_queue.sv
      - source/ncq_global_monitor.sv
      - source/ncq_resp_gen.sv
      - source/ncq_excl_top.sv
  - target: test
    files:
      - tb/ncq_excl_checker.sv
      - tb/ncq_excl_tb.sv
